// File: hdl/autofire.sv
/*
 * Square wave while a button is held. Each half lasts
 * autofire_half cycles, autofire_half must be at least 1.
 * Releasing the button restarts the phase at once.
 */
module autofire import pad_pkg::*; #(
    parameter int autofire_half = autofire_half_default
) (
    input  logic clk,
    input  logic sys_resetn,
    input  logic held,
    output logic out
);

    localparam int cnt_w = (autofire_half > 1) ? $clog2(autofire_half) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(autofire_half - 1);

    logic [cnt_w-1:0] count;
    logic             running;  // held seen on an earlier edge
    logic             wave;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            count   <= '0;
            running <= 1'b0;
            wave    <= 1'b0;
        end else if (!held) begin
            // released, park the phase
            count   <= '0;
            running <= 1'b0;
            wave    <= 1'b0;
        end else if (!running) begin
            count   <= '0;
            running <= 1'b1;
            wave    <= 1'b1;    // fire immediately on press
        end else if (count == cnt_last) begin
            count <= '0;
            wave  <= ~wave;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign out = wave;

endmodule

// File: hdl/joypad_port.sv
/*
 * NES joypad side, one 8-bit shift register per port.
 * Strobe has priority over a clock edge in the same cycle.
 * The joypad clocks are sampled in the clk domain, an edge
 * is seen one cycle after the clock bit goes low.
 */
module joypad_port import pad_pkg::*; (
    input  logic                    clk,
    input  logic                    sys_resetn,
    input  nes_buttons_t            pad1,
    input  nes_buttons_t            pad2,
    input  logic                    joypad_strobe,
    input  logic [joypad_ports-1:0] joypad_clock,
    output logic [joypad_ports-1:0] joypad_data,
    output logic                    home_request
);

    nes_buttons_t            pad_in [joypad_ports];
    logic [7:0]              shift_q [joypad_ports];
    logic [joypad_ports-1:0] clock_prev;
    logic [joypad_ports-1:0] clock_fall;

    assign pad_in[0] = pad1;
    assign pad_in[1] = pad2;

    assign clock_fall = clock_prev & ~joypad_clock;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            clock_prev <= '0;
        end else begin
            clock_prev <= joypad_clock;
        end
    end

    ////////////////////////////////////////////////////////////
    // shift registers
    ////////////////////////////////////////////////////////////

    for (genvar p = 0; p < joypad_ports; p++) begin : g_port
        always_ff @(posedge clk) begin
            if (!sys_resetn) begin
                shift_q[p] <= '0;
            end else if (joypad_strobe) begin
                shift_q[p] <= pad_in[p];            // A lands in bit 0
            end else if (clock_fall[p]) begin
                shift_q[p] <= {1'b1, shift_q[p][7:1]};  // ones after the 8th read
            end
        end

        assign joypad_data[p] = shift_q[p][0];
    end

    ////////////////////////////////////////////////////////////
    // home combination
    ////////////////////////////////////////////////////////////

    // select + down on player 1 only
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            home_request <= 1'b0;
        end else begin
            home_request <= pad1.select & pad1.down;
        end
    end

endmodule

// File: hdl/pad_channel.sv
/*
 * One player's Dualshock bytes to NES buttons.
 * The rx bytes are sampled once per clock with no sync stage,
 * so they must already be in the clk domain.
 * Square adds autofire to B, triangle adds autofire to A.
 */
module pad_channel import pad_pkg::*; #(
    parameter int autofire_half = autofire_half_default
) (
    input  logic          clk,
    input  logic          sys_resetn,
    input  dualshock_rx_t rx,
    output nes_buttons_t  buttons
);

    dualshock_rx_t rx_q;
    dualshock_rx_t pressed;     // active high copy of rx_q
    logic          auto_square;
    logic          auto_triangle;

    ////////////////////////////////////////////////////////////
    // input register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            rx_q <= rx_released;
        end else begin
            rx_q <= rx;
        end
    end

    assign pressed = ~rx_q;

    ////////////////////////////////////////////////////////////
    // autofire
    ////////////////////////////////////////////////////////////

    autofire #(
        .autofire_half (autofire_half)
    ) af_square (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .held       (pressed.btn1[7]),  // square
        .out        (auto_square)
    );

    autofire #(
        .autofire_half (autofire_half)
    ) af_triangle (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .held       (pressed.btn1[4]),  // triangle
        .out        (auto_triangle)
    );

    ////////////////////////////////////////////////////////////
    // reorder into NES button order
    ////////////////////////////////////////////////////////////

    always_comb begin
        buttons.right  = pressed.btn0[5];
        buttons.left   = pressed.btn0[7];
        buttons.down   = pressed.btn0[6];
        buttons.up     = pressed.btn0[4];
        buttons.start  = pressed.btn0[3];
        buttons.select = pressed.btn0[0];
        // cross is B, circle is A
        buttons.b      = pressed.btn1[6] | auto_square;
        buttons.a      = pressed.btn1[5] | auto_triangle;
    end

endmodule

// File: hdl/pad_pkg.sv
/*
 * Shared types and constants for the controller path.
 * Dualshock bytes are active low as received from the pad,
 * NES buttons are active high. Only two joypad ports exist.
 */
package pad_pkg;

    ////////////////////////////////////////////////////////////
    // pad payloads
    ////////////////////////////////////////////////////////////

    // raw receive bytes, active low
    typedef struct packed {
        logic [7:0] btn0;   // L D R U St R3 L3 Se
        logic [7:0] btn1;   // square cross circle triangle R1 L1 R2 L2
    } dualshock_rx_t;

    // NES button order, as the joypad shifts it out from bit 0
    typedef struct packed {
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic b;
        logic a;
    } nes_buttons_t;

    ////////////////////////////////////////////////////////////
    // defaults
    ////////////////////////////////////////////////////////////

    // cycles per autofire half period, roughly 60 ms at 21.477 MHz
    localparam int autofire_half_default = 1_288_620;

    localparam int joypad_ports = 2;

    // idle pad, nothing pressed
    localparam dualshock_rx_t rx_released = '{btn0: 8'hff, btn1: 8'hff};

endpackage

// File: hdl/pad_top.sv
/*
 * Controller path top level, two Dualshock players to the
 * NES joypad protocol. No synchronizers on any input, all
 * inputs are expected in the clk domain.
 */
module pad_top import pad_pkg::*; #(
    parameter int autofire_half = autofire_half_default
) (
    input  logic                    clk,
    input  logic                    sys_resetn,
    input  dualshock_rx_t           pad1_rx,
    input  dualshock_rx_t           pad2_rx,
    input  logic                    joypad_strobe,
    input  logic [joypad_ports-1:0] joypad_clock,
    output logic [joypad_ports-1:0] joypad_data,
    output logic                    home_request
);

    nes_buttons_t buttons1;
    nes_buttons_t buttons2;

    pad_channel #(
        .autofire_half (autofire_half)
    ) ch1_i (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .rx         (pad1_rx),
        .buttons    (buttons1)
    );

    pad_channel #(
        .autofire_half (autofire_half)
    ) ch2_i (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .rx         (pad2_rx),
        .buttons    (buttons2)
    );

    // console facing shift registers
    joypad_port port_i (
        .clk           (clk),
        .sys_resetn    (sys_resetn),
        .pad1          (buttons1),
        .pad2          (buttons2),
        .joypad_strobe (joypad_strobe),
        .joypad_clock  (joypad_clock),
        .joypad_data   (joypad_data),
        .home_request  (home_request)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build tb_pad_top with Verilator, run it, and judge the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_pad_top -o tb_pad_top

# the log decides pass or fail, not the exit status
./obj_dir/tb_pad_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
fi
echo "run.sh: simulation failed"
exit 1

// File: test/pad_model.svh
/*
 * Cycle model of both pad channels and the joypad port.
 * Included inside tb_pad_top, which must declare af_half first.
 * model_step runs once per rising clock edge on the sampled inputs.
 */
`ifndef PAD_MODEL_SVH
`define PAD_MODEL_SVH

dualshock_rx_t m_rx_q [2];      // registered pad bytes
int            m_af_cnt [4];    // index 2*player + (0 square, 1 triangle)
logic          m_af_out [4];
logic          m_af_prev [4];   // held level seen at the previous edge
logic [7:0]    m_shift [2];
logic [1:0]    m_clk_prev;
logic          m_home;

// Dualshock bytes to NES order, autofire ORed into B and A
function automatic nes_buttons_t nes_map(input dualshock_rx_t rx, input logic af_b,
                                         input logic af_a);
    nes_buttons_t nb;
    nb.right  = ~rx.btn0[5];
    nb.left   = ~rx.btn0[7];
    nb.down   = ~rx.btn0[6];
    nb.up     = ~rx.btn0[4];
    nb.start  = ~rx.btn0[3];
    nb.select = ~rx.btn0[0];
    nb.b      = ~rx.btn1[6] | af_b;
    nb.a      = ~rx.btn1[5] | af_a;
    return nb;
endfunction

// {home_request, joypad_data[1], joypad_data[0]}
function automatic logic [2:0] model_outputs();
    return {m_home, m_shift[1][0], m_shift[0][0]};
endfunction

task automatic model_step(input logic rst_n, input dualshock_rx_t rx1,
                          input dualshock_rx_t rx2, input logic strobe,
                          input logic [1:0] clock);
    nes_buttons_t  btn [2];
    dualshock_rx_t rxq;
    logic          held;
    int            i;
    if (!rst_n) begin
        for (i = 0; i < 2; i++) begin
            m_rx_q[i]  = 16'hffff;  // nothing pressed
            m_shift[i] = 8'h00;
        end
        for (i = 0; i < 4; i++) begin
            m_af_cnt[i]  = 0;
            m_af_out[i]  = 1'b0;
            m_af_prev[i] = 1'b0;
        end
        m_clk_prev = 2'b00;
        m_home     = 1'b0;
    end else begin
        ////////////////////////////////////////////////////////////
        // joypad side, uses the buttons before this edge
        ////////////////////////////////////////////////////////////
        for (i = 0; i < 2; i++) begin
            btn[i] = nes_map(m_rx_q[i], m_af_out[2*i], m_af_out[2*i+1]);
            if (strobe) begin
                m_shift[i] = btn[i];
            end else if (m_clk_prev[i] && !clock[i]) begin
                m_shift[i] = {1'b1, m_shift[i][7:1]};
            end
        end
        m_clk_prev = clock;
        m_home     = btn[0].select & btn[0].down;

        // autofire sees the registered rx, not the new input
        for (i = 0; i < 4; i++) begin
            rxq  = m_rx_q[i/2];
            held = (i % 2 == 0) ? ~rxq.btn1[7] : ~rxq.btn1[4];
            if (!held) begin
                m_af_cnt[i] = 0;
                m_af_out[i] = 1'b0;
            end else if (!m_af_prev[i]) begin
                m_af_cnt[i] = 0;
                m_af_out[i] = 1'b1;     // first edge of the press
            end else if (m_af_cnt[i] == af_half - 1) begin
                m_af_cnt[i] = 0;
                m_af_out[i] = ~m_af_out[i];
            end else begin
                m_af_cnt[i] = m_af_cnt[i] + 1;
            end
            m_af_prev[i] = held;
        end
        m_rx_q[0] = rx1;
        m_rx_q[1] = rx2;
    end
endtask

`endif

// File: test/tb_pad_top.sv
/*
 * Testbench for pad_top with a 6 cycle autofire half period.
 * Inputs change 1 time unit after each rising edge. Outputs
 * are compared with the model on every falling edge.
 */
module tb_pad_top import pad_pkg::*; ();

    localparam int af_half = 6;

    logic          clk = 1'b0;
    logic          sys_resetn;
    dualshock_rx_t pad1_rx;
    dualshock_rx_t pad2_rx;
    logic          joypad_strobe;
    logic [1:0]    joypad_clock;
    logic [1:0]    joypad_data;
    logic          home_request;

    integer seed = 96969;
    int     mismatches = 0;
    int     other_errors = 0;
    logic   check_on = 1'b0;
    string  test_name = "reset";

    `include "pad_model.svh"

    pad_top #(
        .autofire_half (af_half)
    ) dut_i (
        .clk           (clk),
        .sys_resetn    (sys_resetn),
        .pad1_rx       (pad1_rx),
        .pad2_rx       (pad2_rx),
        .joypad_strobe (joypad_strobe),
        .joypad_clock  (joypad_clock),
        .joypad_data   (joypad_data),
        .home_request  (home_request)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        model_step(sys_resetn, pad1_rx, pad2_rx, joypad_strobe, joypad_clock);
    end

    always @(negedge clk) begin
        if (check_on) begin
            check({test_name, " model"}, 32'(model_outputs()), 32'({home_request, joypad_data}));
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            mismatches++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        other_errors++;
        $display("timeout in %s: %s did not happen in time", test_name, what);
    endtask

    task automatic wait_for_data(input int port, input logic level, input int limit,
                                 output int n);
        n = 0;
        while (joypad_data[port] !== level && n < limit) begin
            tick();
            n++;
        end
        if (joypad_data[port] !== level) report_timeout("joypad_data change");
    endtask

    task automatic wait_for_home(input logic level, input int limit, output int n);
        n = 0;
        while (home_request !== level && n < limit) begin
            tick();
            n++;
        end
        if (home_request !== level) report_timeout("home_request change");
    endtask

    // strobe then eight reads with a falling clock after each
    task automatic read_serial(output logic [7:0] got1, output logic [7:0] got2,
                               output logic [7:0] loaded1, output logic [7:0] loaded2);
        int i;
        joypad_strobe = 1'b1;
        tick();
        loaded1       = m_shift[0];
        loaded2       = m_shift[1];
        joypad_strobe = 1'b0;
        for (i = 0; i < 8; i++) begin
            joypad_clock = 2'b11;
            tick();
            got1[i]      = joypad_data[0];
            got2[i]      = joypad_data[1];
            joypad_clock = 2'b00;
            tick();
        end
        check({test_name, " fill"}, 32'd3, 32'(joypad_data));   // ones from the top
    endtask

    function automatic dualshock_rx_t random_plain_rx();
        dualshock_rx_t rx;
        rx.btn0 = 8'($random(seed));
        rx.btn1 = 8'($random(seed)) | 8'h90;    // square and triangle released
        return rx;
    endfunction

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state_reads();
        logic [7:0] g1, g2, l1, l2;
        test_name = "reset";
        check("reset home", 32'd0, 32'(home_request));
        read_serial(g1, g2, l1, l2);
        check("reset port1", 32'd0, 32'(g1));
        check("reset port2", 32'd0, 32'(g2));
    endtask

    task automatic plain_mapping();
        logic [7:0]    g1, g2, l1, l2;
        dualshock_rx_t r1, r2;
        test_name = "plain";
        repeat (8) begin
            r1      = random_plain_rx();
            r2      = random_plain_rx();
            pad1_rx = r1;
            pad2_rx = r2;
            tick();
            tick();
            read_serial(g1, g2, l1, l2);
            check("plain port1", 32'(nes_map(r1, 1'b0, 1'b0)), 32'(g1));
            check("plain port2", 32'(nes_map(r2, 1'b0, 1'b0)), 32'(g2));
            check("plain port1 model", 32'(l1), 32'(g1));
            check("plain port2 model", 32'(l2), 32'(g2));
        end
    endtask

    task automatic autofire_runs();
        logic [7:0] g1, g2, l1, l2;
        int         n;
        logic       level;
        test_name     = "autofire";
        pad1_rx       = 16'hffff;
        pad2_rx       = 16'hffff;
        joypad_strobe = 1'b1;       // A of port 2 on joypad_data every cycle
        repeat (3) tick();
        pad1_rx.btn1 = 8'h7f;       // square on player 1
        pad2_rx.btn1 = 8'hef;       // triangle on player 2
        wait_for_data(1, 1'b1, 10, n);
        check("autofire press delay", 32'd3, 32'(n));
        level = 1'b1;
        repeat (4) begin
            wait_for_data(1, ~level, 3 * af_half, n);
            check("autofire run", af_half, 32'(n));
            level = ~level;
        end
        // release in the middle of a high run and press again
        wait_for_data(1, 1'b1, 3 * af_half, n);
        tick();
        tick();
        pad2_rx = 16'hffff;
        wait_for_data(1, 1'b0, 10, n);
        check("autofire release delay", 32'd3, 32'(n));
        pad2_rx.btn1 = 8'hef;
        wait_for_data(1, 1'b1, 10, n);
        check("autofire repress delay", 32'd3, 32'(n));
        wait_for_data(1, 1'b0, 3 * af_half, n);
        check("autofire restarted run", af_half, 32'(n));
        repeat (4) begin
            read_serial(g1, g2, l1, l2);
            check("autofire port1 byte", 32'(l1), 32'(g1));
            check("autofire port2 byte", 32'(l2), 32'(g2));
        end
        pad1_rx = 16'hffff;
        pad2_rx = 16'hffff;
    endtask

    task automatic interleaved_shifts();
        logic [7:0] expect_byte [2];
        logic [1:0] prev;
        logic [1:0] c;
        logic [1:0] fall;
        int         k [2];
        int         p;
        test_name      = "shift";
        pad1_rx        = random_plain_rx();
        pad2_rx        = random_plain_rx();
        expect_byte[0] = nes_map(pad1_rx, 1'b0, 1'b0);
        expect_byte[1] = nes_map(pad2_rx, 1'b0, 1'b0);
        joypad_clock   = 2'b00;
        tick();
        tick();
        joypad_strobe = 1'b1;
        tick();
        joypad_strobe = 1'b0;
        prev = 2'b00;
        k[0] = 0;
        k[1] = 0;
        repeat (80) begin
            c            = 2'($random(seed));
            fall         = prev & ~c;
            joypad_clock = c;
            tick();
            for (p = 0; p < 2; p++) begin
                if (fall[p]) k[p]++;
                check("shift data", 32'((k[p] < 8) ? expect_byte[p][k[p]] : 1'b1),
                      32'(joypad_data[p]));
            end
            prev = c;
        end
        joypad_clock = 2'b00;
    endtask

    task automatic home_combination();
        int n;
        test_name = "home";
        pad1_rx   = 16'hffff;
        pad2_rx   = 16'hffff;
        repeat (3) tick();
        check("home idle", 32'd0, 32'(home_request));
        pad1_rx.btn0 = 8'hbe;       // select and down
        wait_for_home(1'b1, 10, n);
        check("home rise delay", 32'd2, 32'(n));
        pad1_rx = 16'hffff;
        wait_for_home(1'b0, 10, n);
        check("home fall delay", 32'd2, 32'(n));
        pad2_rx.btn0 = 8'hbe;       // player 2 must not count
        repeat (6) begin
            tick();
            check("home player 2", 32'd0, 32'(home_request));
        end
        pad2_rx = 16'hffff;
    endtask

    task automatic random_soak();
        test_name = "soak";
        repeat (2000) begin
            if (($random(seed) & 15) == 0) pad1_rx = 16'($random(seed));
            if (($random(seed) & 15) == 0) pad2_rx = 16'($random(seed));
            joypad_strobe = (($random(seed) & 7) == 0);
            joypad_clock  = 2'($random(seed));
            tick();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        sys_resetn    = 1'b0;
        pad1_rx       = 16'hffff;
        pad2_rx       = 16'hffff;
        joypad_strobe = 1'b0;
        joypad_clock  = 2'b00;
        repeat (10) tick();
        sys_resetn = 1'b1;
        check_on   = 1'b1;
        reset_state_reads();
        plain_mapping();
        autofire_runs();
        interleaved_shifts();
        home_combination();
        random_soak();
        finish_run();
    end

endmodule

// File: vlog.f
+incdir+test
hdl/pad_pkg.sv
hdl/autofire.sv
hdl/pad_channel.sv
hdl/joypad_port.sv
hdl/pad_top.sv
test/tb_pad_top.sv
